// ==== verilog/memPkg.sv ====
package memPkg;

  // Byte address as issued by the core
  typedef logic [31:0] addr_t;

  // One bus and cache word
  typedef logic [31:0] word_t;

  // One enable bit per byte lane of a word
  typedef logic [3:0] byteMask_t;

  // Request from a cache toward memory
  // Held steady by the master until ready pulses
  typedef struct packed {
    // Stays high until the last beat completes
    logic  req;
    logic  write;
    // Always word aligned
    addr_t addr;
    // Ignored on reads
    word_t wdata;
  } busReq_t;

  // Response from memory toward the requester
  typedef struct packed {
    // One-cycle pulse per completed beat
    logic  ready;
    // Only meaningful while ready is high
    word_t rdata;
  } busRsp_t;

endpackage

// ==== verilog/instrCache.sv ====
`timescale 1ns/1ps

// Direct-mapped read-only instruction cache
// Misses fetch the whole line over the shared bus
module instrCache #(
  parameter int BlockWords = 4,
  parameter int NumLines   = 16
) (
  input  logic            clk,
  input  logic            rstN,
  input  memPkg::addr_t   pcF,
  input  memPkg::busRsp_t busRsp,
  output memPkg::word_t   instrF,
  output logic            iStall,
  output memPkg::busReq_t busReq
);

  // Address split: tag | index | word offset | byte offset
  localparam int AddrBits = $bits(memPkg::addr_t);
  localparam int OffBits  = $clog2(BlockWords);
  localparam int IdxBits  = $clog2(NumLines);
  localparam int TagBits  = AddrBits - 2 - OffBits - IdxBits;

  typedef enum logic {
    Idle,
    Fill
  } fillState_t;

  fillState_t state;

  // Word within the line being fetched
  logic [OffBits-1:0] beatCnt;
  logic               lastBeat;

  // Per-line control and payload
  logic [NumLines-1:0] valid;
  logic [TagBits-1:0]  tags [NumLines];
  memPkg::word_t       lineData [NumLines*BlockWords];

  // Fields of the fetch address
  logic [TagBits-1:0] pcTag;
  logic [IdxBits-1:0] pcIdx;
  logic [OffBits-1:0] pcOff;
  logic               hit;

  assign pcTag = pcF[AddrBits-1 -: TagBits];
  assign pcIdx = pcF[2+OffBits +: IdxBits];
  assign pcOff = pcF[2 +: OffBits];

  // Tag compare against the indexed line
  assign hit = valid[pcIdx] && (tags[pcIdx] == pcTag);

  // Hit data comes straight out of the array
  assign instrF = lineData[{pcIdx, pcOff}];

  // Stall covers the miss cycle and the whole fill
  assign iStall = !hit || (state != Idle);

  assign lastBeat = &beatCnt;

  // Fill walks the line from its base word upward
  // Fetch address stays put while stalled so pcF is safe to use here
  always_comb begin
    busReq       = '0;
    busReq.req   = (state == Fill);
    busReq.write = 1'b0;
    busReq.addr  = {pcTag, pcIdx, beatCnt, 2'b00};
    busReq.wdata = '0;
  end

  // Fill FSM and valid bits
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state   <= Idle;
      beatCnt <= '0;
      valid   <= '0;
    end else begin
      case (state)
        Idle: begin
          if (!hit) begin
            beatCnt <= '0;
            state   <= Fill;
          end
        end
        Fill: begin
          if (busRsp.ready) begin
            beatCnt <= beatCnt + 1'b1;
            // Line becomes usable only once every word is in
            if (lastBeat) begin
              valid[pcIdx] <= 1'b1;
              state        <= Idle;
            end
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  // Line words and tag land as the beats return
  always_ff @(posedge clk) begin
    if ((state == Fill) && busRsp.ready) begin
      lineData[{pcIdx, beatCnt}] <= busRsp.rdata;
      if (lastBeat) begin
        tags[pcIdx] <= pcTag;
      end
    end
  end

endmodule

// ==== verilog/dataCache.sv ====
`timescale 1ns/1ps

// Direct-mapped write-back, write-allocate data cache
// Byte-masked writes merge into the cached word
module dataCache #(
  parameter int BlockWords = 4,
  parameter int NumLines   = 16
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              memReadM,
  input  logic              memWriteM,
  input  memPkg::addr_t     dataAdrM,
  input  memPkg::word_t     writeDataM,
  input  memPkg::byteMask_t byteMaskM,
  input  memPkg::busRsp_t   busRsp,
  output memPkg::word_t     readDataM,
  output logic              dStall,
  output memPkg::busReq_t   busReq
);

  // Address split: tag | index | word offset | byte offset
  localparam int AddrBits = $bits(memPkg::addr_t);
  localparam int Lanes    = $bits(memPkg::byteMask_t);
  localparam int OffBits  = $clog2(BlockWords);
  localparam int IdxBits  = $clog2(NumLines);
  localparam int TagBits  = AddrBits - 2 - OffBits - IdxBits;

  typedef enum logic [1:0] {
    Idle,
    WriteBack,
    Fill
  } cacheState_t;

  cacheState_t state;

  // Word position inside the line for both victim and fill beats
  logic [OffBits-1:0] beatCnt;
  logic               lastBeat;

  // Per-line control
  logic [NumLines-1:0] valid;
  logic [NumLines-1:0] dirty;

  // Per-line payload
  logic [TagBits-1:0] tags [NumLines];
  memPkg::word_t      lineData [NumLines*BlockWords];

  // Fields of the access address
  logic [TagBits-1:0] reqTag;
  logic [IdxBits-1:0] reqIdx;
  logic [OffBits-1:0] reqOff;

  logic          access;
  logic          hit;
  logic          writeHit;
  memPkg::word_t mergedWord;

  assign reqTag = dataAdrM[AddrBits-1 -: TagBits];
  assign reqIdx = dataAdrM[2+OffBits +: IdxBits];
  assign reqOff = dataAdrM[2 +: OffBits];

  assign access = memReadM || memWriteM;
  assign hit    = valid[reqIdx] && (tags[reqIdx] == reqTag);

  // Write hits only retire from Idle
  assign writeHit = memWriteM && hit && (state == Idle);

  assign readDataM = lineData[{reqIdx, reqOff}];

  // No access means no stall, whatever the line holds
  assign dStall = access && (!hit || (state != Idle));

  assign lastBeat = &beatCnt;

  // Enabled lanes take the new bytes, the rest keep the cached ones
  always_comb begin
    mergedWord = lineData[{reqIdx, reqOff}];
    for (int b = 0; b < Lanes; b++) begin
      if (byteMaskM[b]) begin
        mergedWord[8*b +: 8] = writeDataM[8*b +: 8];
      end
    end
  end

  // Bus side of the miss FSM
  always_comb begin
    busReq.req   = 1'b0;
    busReq.write = 1'b0;
    busReq.addr  = {reqTag, reqIdx, beatCnt, 2'b00};
    busReq.wdata = lineData[{reqIdx, beatCnt}];
    case (state)
      WriteBack: begin
        // Victim goes back to the address its own tag names
        busReq.req   = 1'b1;
        busReq.write = 1'b1;
        busReq.addr  = {tags[reqIdx], reqIdx, beatCnt, 2'b00};
      end
      Fill: begin
        busReq.req = 1'b1;
      end
      default: busReq.req = 1'b0;
    endcase
  end

  // Miss FSM with valid and dirty bookkeeping
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state   <= Idle;
      beatCnt <= '0;
      valid   <= '0;
      dirty   <= '0;
    end else begin
      case (state)
        Idle: begin
          if (access && !hit) begin
            beatCnt <= '0;
            // Clean or empty victims skip straight to the fill
            if (valid[reqIdx] && dirty[reqIdx]) begin
              state <= WriteBack;
            end else begin
              state <= Fill;
            end
          end else if (writeHit) begin
            dirty[reqIdx] <= 1'b1;
          end
        end
        WriteBack: begin
          if (busRsp.ready) begin
            // Counter wraps to zero for the fill
            beatCnt <= beatCnt + 1'b1;
            if (lastBeat) begin
              state <= Fill;
            end
          end
        end
        Fill: begin
          if (busRsp.ready) begin
            beatCnt <= beatCnt + 1'b1;
            if (lastBeat) begin
              valid[reqIdx] <= 1'b1;
              dirty[reqIdx] <= 1'b0;
              state         <= Idle;
            end
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  // Line payload from either a write hit or a returning fill beat
  always_ff @(posedge clk) begin
    if (writeHit) begin
      lineData[{reqIdx, reqOff}] <= mergedWord;
    end
    if ((state == Fill) && busRsp.ready) begin
      lineData[{reqIdx, beatCnt}] <= busRsp.rdata;
      if (lastBeat) begin
        tags[reqIdx] <= reqTag;
      end
    end
  end

endmodule

// ==== verilog/busArbiter.sv ====
`timescale 1ns/1ps

// Shares the memory bus between the two caches
// Data side wins when both ask on an idle bus
module busArbiter (
  input  logic            clk,
  input  logic            rstN,
  input  memPkg::busReq_t iReq,
  input  memPkg::busReq_t dReq,
  input  memPkg::busRsp_t memRsp,
  output memPkg::busReq_t memReq,
  output memPkg::busRsp_t iRsp,
  output memPkg::busRsp_t dRsp
);

  typedef enum logic [1:0] {
    GrantNone,
    GrantInstr,
    GrantData
  } grant_t;

  // Owner from last cycle and owner for this cycle
  grant_t grantQ;
  grant_t grantNow;

  // Holder keeps the bus while its req stays up
  // Otherwise a fresh pick, data first
  always_comb begin
    if ((grantQ == GrantData) && dReq.req) begin
      grantNow = GrantData;
    end else if ((grantQ == GrantInstr) && iReq.req) begin
      grantNow = GrantInstr;
    end else if (dReq.req) begin
      grantNow = GrantData;
    end else if (iReq.req) begin
      grantNow = GrantInstr;
    end else begin
      grantNow = GrantNone;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      grantQ <= GrantNone;
    end else begin
      grantQ <= grantNow;
    end
  end

  // Idle bus shows req low
  assign memReq = (grantNow == GrantData)  ? dReq :
                  (grantNow == GrantInstr) ? iReq : '0;

  // Ready only reaches the owner; rdata can fan out freely
  assign iRsp.ready = memRsp.ready && (grantNow == GrantInstr);
  assign iRsp.rdata = memRsp.rdata;
  assign dRsp.ready = memRsp.ready && (grantNow == GrantData);
  assign dRsp.rdata = memRsp.rdata;

endmodule

// ==== verilog/busMemory.sv ====
`timescale 1ns/1ps

// Word-wide simulation memory
// Every beat answers a fixed number of cycles after its address shows up
module busMemory #(
  parameter int MemWords    = 1024,
  parameter int ReadLatency = 2
) (
  input  logic            clk,
  input  logic            rstN,
  input  memPkg::busReq_t memReq,
  output memPkg::busRsp_t memRsp
);

  localparam int IdxBits = $clog2(MemWords);
  localparam int CntBits = $clog2(ReadLatency + 1);

  memPkg::word_t mem [MemWords];

  // Beat in progress and cycles spent on it
  logic               busy;
  logic [CntBits-1:0] cycleCnt;
  logic               beatDone;

  // Word index wraps around the memory depth
  logic [IdxBits-1:0] wordIdx;

  // Contents start cleared
  initial begin
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = '0;
    end
  end

  assign wordIdx = IdxBits'(memReq.addr[31:2] % MemWords);

  // Counter reaches the latency exactly on the answering cycle
  assign beatDone = busy && (cycleCnt == CntBits'(ReadLatency));

  assign memRsp.ready = beatDone;
  assign memRsp.rdata = mem[wordIdx];

  // Beat timing
  always_ff @(posedge clk) begin
    if (!rstN) begin
      busy     <= 1'b0;
      cycleCnt <= '0;
    end else if (!busy) begin
      // First cycle of the address counts as cycle one
      if (memReq.req) begin
        busy     <= 1'b1;
        cycleCnt <= CntBits'(1);
      end
    end else if (beatDone) begin
      busy     <= 1'b0;
      cycleCnt <= '0;
    end else begin
      cycleCnt <= cycleCnt + 1'b1;
    end
  end

  // Writes commit on the answering cycle
  always_ff @(posedge clk) begin
    if (beatDone && memReq.write) begin
      mem[wordIdx] <= memReq.wdata;
    end
  end

endmodule

// ==== verilog/memSubsystem.sv ====
`timescale 1ns/1ps

// Memory side of the core: two caches over one arbitrated bus
module memSubsystem #(
  parameter int BlockWords  = 4,
  parameter int NumLines    = 16,
  parameter int MemWords    = 1024,
  parameter int ReadLatency = 2
) (
  input  logic              clk,
  input  logic              rstN,
  // Fetch side
  input  memPkg::addr_t     pcF,
  output memPkg::word_t     instrF,
  output logic              iStall,
  // Memory stage side
  input  logic              memReadM,
  input  logic              memWriteM,
  input  memPkg::addr_t     dataAdrM,
  input  memPkg::word_t     writeDataM,
  input  memPkg::byteMask_t byteMaskM,
  output memPkg::word_t     readDataM,
  output logic              dStall
);

  // Cache side of the arbiter
  memPkg::busReq_t iReq;
  memPkg::busReq_t dReq;
  memPkg::busRsp_t iRsp;
  memPkg::busRsp_t dRsp;

  // Memory side of the arbiter
  memPkg::busReq_t memReq;
  memPkg::busRsp_t memRsp;

  instrCache #(
    .BlockWords(BlockWords),
    .NumLines  (NumLines)
  ) instrCache_inst (
    .clk   (clk),
    .rstN  (rstN),
    .pcF   (pcF),
    .busRsp(iRsp),
    .instrF(instrF),
    .iStall(iStall),
    .busReq(iReq)
  );

  dataCache #(
    .BlockWords(BlockWords),
    .NumLines  (NumLines)
  ) dataCache_inst (
    .clk       (clk),
    .rstN      (rstN),
    .memReadM  (memReadM),
    .memWriteM (memWriteM),
    .dataAdrM  (dataAdrM),
    .writeDataM(writeDataM),
    .byteMaskM (byteMaskM),
    .busRsp    (dRsp),
    .readDataM (readDataM),
    .dStall    (dStall),
    .busReq    (dReq)
  );

  busArbiter busArbiter_inst (
    .clk   (clk),
    .rstN  (rstN),
    .iReq  (iReq),
    .dReq  (dReq),
    .memRsp(memRsp),
    .memReq(memReq),
    .iRsp  (iRsp),
    .dRsp  (dRsp)
  );

  // Fixed-latency backing store
  busMemory #(
    .MemWords   (MemWords),
    .ReadLatency(ReadLatency)
  ) busMemory_inst (
    .clk   (clk),
    .rstN  (rstN),
    .memReq(memReq),
    .memRsp(memRsp)
  );

endmodule

// ==== verification/memSubsystemAssert.sv ====
`timescale 1ns/1ps

// Bus rules checked inside the memory subsystem
module memSubsystemAssert #(
  parameter int ReadLatency = 2
) (
  input logic            clk,
  input logic            rstN,
  input memPkg::busReq_t memReq,
  input memPkg::busRsp_t memRsp,
  input memPkg::busRsp_t iRsp,
  input memPkg::busRsp_t dRsp
);

  // Count of failed assertions
  int failCount = 0;

  // Bus state one cycle back, for spotting where a beat starts
  logic reqQ;
  logic readyQ;
  logic beatStart;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      reqQ   <= 1'b0;
      readyQ <= 1'b0;
    end else begin
      reqQ   <= memReq.req;
      readyQ <= memRsp.ready;
    end
  end

  // New beat: request on a bus that was idle or just finished a beat
  assign beatStart = memReq.req && (!reqQ || readyQ);

  // A beat still waiting for ready keeps its address and data
  holdRequest: assert property (@(posedge clk) disable iff (!rstN)
    (memReq.req && !memRsp.ready) |=>
      (memReq.req && $stable(memReq.addr) && $stable(memReq.wdata)))
    else begin
      failCount++;
      $error("Bus request changed before its ready pulse");
    end

  // Each ready pulse reaches exactly one cache
  oneOwner: assert property (@(posedge clk) disable iff (!rstN)
    memRsp.ready |-> (iRsp.ready != dRsp.ready))
    else begin
      failCount++;
      $error("Ready pulse reached no cache or both caches");
    end

  // Ready comes exactly the fixed latency after each beat starts
  beatLatency: assert property (@(posedge clk) disable iff (!rstN)
    memRsp.ready == $past(beatStart, ReadLatency))
    else begin
      failCount++;
      $error("Bus ready did not follow its beat by the fixed latency");
    end

endmodule

bind memSubsystem memSubsystemAssert #(
  .ReadLatency(ReadLatency)
) memSubsystemAssert_inst (
  .clk   (clk),
  .rstN  (rstN),
  .memReq(memReq),
  .memRsp(memRsp),
  .iRsp  (iRsp),
  .dRsp  (dRsp)
);

// ==== verification/memSubsystemTb.sv ====
`timescale 1ns/1ps

// Stands in for the core on both the fetch and the memory stage ports
module memSubsystemTb;

  // Small caches so that index conflicts come easily
  localparam int BlockWords    = 4;
  localparam int NumLines      = 4;
  localparam int MemWords      = 1024;
  localparam int ReadLatency   = 2;
  localparam int TimeoutCycles = 20000;
  localparam int Seed          = 56442;

  logic                clk;
  logic                rstN;
  memPkg::addr_t       pcF;
  memPkg::word_t       instrF;
  logic                iStall;
  logic                memReadM;
  logic                memWriteM;
  memPkg::addr_t       dataAdrM;
  memPkg::word_t       writeDataM;
  memPkg::byteMask_t   byteMaskM;
  memPkg::word_t       readDataM;
  logic                dStall;

  // Expected memory contents as the data side sees them
  memPkg::word_t shadow [MemWords];

  logic [31:0] lcgState;
  int          cycleCount;
  // Fetch stall seen when the last data access finished
  logic        iStallAtDataDone;
  logic        stallSeen;

  memSubsystem #(
    .BlockWords (BlockWords),
    .NumLines   (NumLines),
    .MemWords   (MemWords),
    .ReadLatency(ReadLatency)
  ) memSubsystem_inst (
    .clk       (clk),
    .rstN      (rstN),
    .pcF       (pcF),
    .instrF    (instrF),
    .iStall    (iStall),
    .memReadM  (memReadM),
    .memWriteM (memWriteM),
    .dataAdrM  (dataAdrM),
    .writeDataM(writeDataM),
    .byteMaskM (byteMaskM),
    .readDataM (readDataM),
    .dStall    (dStall)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  task automatic failRun(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  // Global watchdog over the whole run
  initial begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    failRun("Timeout: the DUT did not finish the tests within the cycle limit");
  end

  // Plain 32-bit LCG
  function automatic memPkg::word_t nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  function automatic int wordIndex(input memPkg::addr_t addr);
    return int'(addr[31:2]) % MemWords;
  endfunction

  task automatic compareWord(input string testName, input memPkg::word_t expected,
                             input memPkg::word_t actual);
    if (actual !== expected) begin
      failRun($sformatf("ERROR %s: expected %h, actual %h", testName, expected, actual));
    end
  endtask

  task automatic compareStall(input string testName, input logic expected,
                              input logic actual);
    if (actual !== expected) begin
      failRun($sformatf("ERROR %s: expected %b, actual %b", testName, expected, actual));
    end
  endtask

  // Byte lanes with mask set take the new data
  task automatic mergeShadow(input memPkg::addr_t addr, input memPkg::word_t data,
                             input memPkg::byteMask_t mask);
    int idx;
    idx = wordIndex(addr);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        shadow[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  // One data access held until dStall is low at a falling edge
  task automatic dataAccess(input string testName, input logic isWrite,
                            input memPkg::addr_t addr, input memPkg::word_t data,
                            input memPkg::byteMask_t mask, output logic sawStall);
    @(posedge clk);
    #1;
    memReadM   = !isWrite;
    memWriteM  = isWrite;
    dataAdrM   = addr;
    writeDataM = data;
    byteMaskM  = mask;
    sawStall   = 1'b0;
    @(negedge clk);
    while (dStall) begin
      sawStall = 1'b1;
      @(negedge clk);
    end
    iStallAtDataDone = iStall;
    if (isWrite) begin
      mergeShadow(addr, data, mask);
    end else begin
      compareWord(testName, shadow[wordIndex(addr)], readDataM);
    end
    // Write merges at this edge
    @(posedge clk);
    #1;
    memReadM  = 1'b0;
    memWriteM = 1'b0;
  endtask

  // Fetch held until iStall is low, compared with memory as last written back
  task automatic fetch(input string testName, input memPkg::addr_t addr);
    @(posedge clk);
    #1;
    pcF = addr;
    @(negedge clk);
    while (iStall) begin
      @(negedge clk);
    end
    compareWord(testName, shadow[wordIndex(addr)], instrF);
  endtask

  task automatic resetTest();
    @(negedge clk);
    compareStall("reset dStall", 1'b0, dStall);
    compareStall("reset iStall", 1'b1, iStall);
    fetch("first fetch", 32'h0);
  endtask

  // Full and partial masks, then read back
  task automatic byteMaskTest();
    dataAccess("mask write", 1'b1, 32'h100, 32'hDEADBEEF, 4'hF, stallSeen);
    dataAccess("mask write", 1'b1, 32'h104, 32'h11223344, 4'b0101, stallSeen);
    dataAccess("mask write", 1'b1, 32'h108, 32'hCAFEF00D, 4'hF, stallSeen);
    dataAccess("mask write", 1'b1, 32'h108, 32'h55667788, 4'b1010, stallSeen);
    for (int w = 0; w < 3; w++) begin
      dataAccess("mask read", 1'b0, 32'h100 + 4 * w, '0, '0, stallSeen);
    end
    dataAccess("repeat read", 1'b0, 32'h100, '0, '0, stallSeen);
    compareStall("repeat read hit", 1'b0, stallSeen);
  endtask

  // Four tags on index 0 force dirty write-backs and refills
  task automatic evictionTest();
    memPkg::addr_t addr;
    for (int t = 0; t < 4; t++) begin
      for (int w = 0; w < 4; w++) begin
        addr = 32'h200 + 32'h40 * t + 4 * w;
        dataAccess("conflict write", 1'b1, addr, nextRandom(), 4'hF, stallSeen);
      end
    end
    for (int t = 0; t < 4; t++) begin
      for (int w = 0; w < 4; w++) begin
        addr = 32'h200 + 32'h40 * t + 4 * w;
        dataAccess("conflict read", 1'b0, addr, '0, '0, stallSeen);
      end
    end
  endtask

  // Every line written so far is back in memory by now
  task automatic fetchAfterEvictTest();
    for (int w = 0; w < 3; w++) begin
      fetch("fetch evicted", 32'h100 + 4 * w);
    end
    for (int t = 0; t < 4; t++) begin
      for (int w = 0; w < 4; w++) begin
        fetch("fetch evicted", 32'h200 + 32'h40 * t + 4 * w);
      end
    end
    // Never written, so zero; also leaves tag 12 on icache index 0
    for (int w = 0; w < 4; w++) begin
      fetch("fetch unwritten", 32'h300 + 4 * w);
    end
  endtask

  // Both sides miss in the same cycle and data must win the bus
  task automatic contentionTest();
    memPkg::addr_t fetchAddr;
    memPkg::addr_t dataAddr;
    memPkg::word_t data;
    for (int r = 0; r < 4; r++) begin
      fetchAddr = 32'h200 + 32'h40 * r + 4 * r;
      dataAddr  = 32'h400 + 32'h40 * r;
      data      = nextRandom();
      fork
        fetch("contention fetch", fetchAddr);
        dataAccess("contention write", 1'b1, dataAddr, data, 4'hF, stallSeen);
      join
      compareStall("contention data first", 1'b1, iStallAtDataDone);
    end
    for (int r = 0; r < 4; r++) begin
      dataAccess("contention read", 1'b0, 32'h400 + 32'h40 * r, '0, '0, stallSeen);
    end
  endtask

  // Random mix over 64 words spread across all four indices
  task automatic randomTest();
    memPkg::word_t r;
    memPkg::addr_t addr;
    for (int n = 0; n < 200; n++) begin
      r    = nextRandom();
      addr = 32'h600 + {r[21:16], 2'b00};
      if (r[24]) begin
        dataAccess("random write", 1'b1, addr, nextRandom(), r[11:8], stallSeen);
      end else begin
        dataAccess("random read", 1'b0, addr, '0, '0, stallSeen);
      end
    end
  endtask

  initial begin
    rstN       = 1'b0;
    pcF        = '0;
    memReadM   = 1'b0;
    memWriteM  = 1'b0;
    dataAdrM   = '0;
    writeDataM = '0;
    byteMaskM  = '0;
    lcgState   = Seed;
    iStallAtDataDone = 1'b0;
    stallSeen  = 1'b0;
    for (int i = 0; i < MemWords; i++) begin
      shadow[i] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
    resetTest();
    byteMaskTest();
    evictionTest();
    fetchAfterEvictTest();
    contentionTest();
    randomTest();
    repeat (2) @(posedge clk);
    if (memSubsystem_inst.memSubsystemAssert_inst.failCount == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Assertion failures: %0d",
               memSubsystem_inst.memSubsystemAssert_inst.failCount);
      $display("Result: FAILED");
      $fatal(1, "Bound assertions failed");
    end
  end

endmodule

// ==== flist.f ====
verilog/memPkg.sv
verilog/instrCache.sv
verilog/dataCache.sv
verilog/busArbiter.sv
verilog/busMemory.sv
verilog/memSubsystem.sv
verification/memSubsystemAssert.sv
verification/memSubsystemTb.sv
